// ==== hw/ialu_consts.svh ====
//--------------------------------------------------------------------------
// Width constants of the integer ALU
// The root engine expects IALU_ROOT_W to be half of IALU_XLEN
// IALU_ROOT_W must divide evenly by IALU_ROOT_STEP
//--------------------------------------------------------------------------

`ifndef IALU_CONSTS_SVH
`define IALU_CONSTS_SVH

//--------------------------------------------------------------------------
// Data path
//--------------------------------------------------------------------------
`define IALU_XLEN       32      // Data word width
`define IALU_SHAMT_W    5       // Shift amount width, log2 of IALU_XLEN

//--------------------------------------------------------------------------
// Square root engine
//--------------------------------------------------------------------------
`define IALU_ROOT_W     16      // Root width
`define IALU_ROOT_STEP  4       // Root bits decided per cycle

// Four steps of four bits cover the whole 16-bit root

`endif

// ==== hw/ialu_cmd_pkg.sv ====
//--------------------------------------------------------------------------
// Command, operation class and root engine state encodings
// SQRT is the only multi-cycle command
//--------------------------------------------------------------------------
`default_nettype none

package ialu_cmd_pkg;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,    // Signed less-than
        SLTU = 4'd6,    // Unsigned less-than
        EQ   = 4'd7,
        NE   = 4'd8,
        GE   = 4'd9,    // Signed greater-or-equal
        GEU  = 4'd10,   // Unsigned greater-or-equal
        SLL  = 4'd11,
        SRL  = 4'd12,
        SRA  = 4'd13,
        SQRT = 4'd14    // Unsigned floor square root
    } ialu_cmd_e;

    typedef enum logic [2:0] {
        ARITH = 3'd0,   // Adder result
        LOGIC = 3'd1,
        CMP   = 3'd2,   // Flag based compare
        SHIFT = 3'd3,
        ROOT  = 3'd4    // Iterative root engine
    } ialu_class_e;

    typedef enum logic [1:0] {
        STEP0 = 2'd0,   // Idle, or first four bits
        STEP1 = 2'd1,
        STEP2 = 2'd2,
        STEP3 = 2'd3    // Last four bits, result out
    } ialu_root_state_e;

endpackage : ialu_cmd_pkg

`default_nettype wire

// ==== hw/ialu_data_pkg.sv ====
//--------------------------------------------------------------------------
// Data types shared by the ALU stages
// Widths come from the constants header
//--------------------------------------------------------------------------
`default_nettype none

`include "ialu_consts.svh"

package ialu_data_pkg;

    import ialu_cmd_pkg::*;

    //----------------------------------------------------------------------
    // Plain vectors
    //----------------------------------------------------------------------
    typedef logic [`IALU_XLEN-1:0]    ialu_word_t;      // Operand or result word
    typedef logic [`IALU_SHAMT_W-1:0] ialu_shamt_t;     // Shift amount

    //----------------------------------------------------------------------
    // Adder flags
    //----------------------------------------------------------------------
    typedef struct packed {
        logic zero;         // Low XLEN bits all zero
        logic sign;         // MSB of the result
        logic overflow;     // Signed overflow of op1 - op2
        logic carry;        // Borrow out, unsigned op1 < op2
    } ialu_flags_s;

    //----------------------------------------------------------------------
    // Issue register contents
    //----------------------------------------------------------------------
    typedef struct packed {
        ialu_cmd_e   cmd;
        ialu_class_e op_class;      // Selects the result source
        ialu_word_t  op1;
        ialu_word_t  op2;
        logic        sub;           // Adder subtracts
        logic        shift_right;
        logic        shift_arith;   // Sign fill on right shift
    } ialu_issue_s;

endpackage : ialu_data_pkg

`default_nettype wire

// ==== hw/ialu_issue.sv ====
//--------------------------------------------------------------------------
// Issue stage of the ALU
// Inputs must stay stable until accepted while ialu_rdy is high
// The register holds its contents while the execute stage stalls
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ialu_issue
    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ialu_vd,
    input  ialu_cmd_e   ialu_cmd,
    input  ialu_word_t  ialu_op1,
    input  ialu_word_t  ialu_op2,
    input  logic        exec_stall,
    output logic        ialu_rdy,
    output logic        issue_vd,
    output ialu_issue_s issue
);

    logic        accept;        // Operation taken this cycle
    ialu_issue_s decoded;       // Next issue register contents

    assign ialu_rdy = ~exec_stall;
    assign accept   = ialu_vd & ialu_rdy;

    //----------------------------------------------------------------------
    // Command decode
    //----------------------------------------------------------------------
    always_comb begin
        decoded.cmd         = ialu_cmd;
        decoded.op1         = ialu_op1;
        decoded.op2         = ialu_op2;
        decoded.sub         = (ialu_cmd != ADD);     // Compares subtract too
        decoded.shift_right = (ialu_cmd == SRL) | (ialu_cmd == SRA);
        decoded.shift_arith = (ialu_cmd == SRA);
        case (ialu_cmd)
            ADD, SUB:                   decoded.op_class = ARITH;
            AND, OR, XOR:               decoded.op_class = LOGIC;
            SLT, SLTU, EQ, NE, GE, GEU: decoded.op_class = CMP;
            SLL, SRL, SRA:              decoded.op_class = SHIFT;
            SQRT:                       decoded.op_class = ROOT;
            default:                    decoded.op_class = ARITH;
        endcase
    end

    //----------------------------------------------------------------------
    // Issue register
    //----------------------------------------------------------------------
    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            issue_vd <= 1'b0;
        end else if (~exec_stall) begin
            issue_vd <= accept;     // Drops when nothing is taken
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue <= decoded;
        end
    end

endmodule : ialu_issue

`default_nettype wire

// ==== hw/ialu_sqrt_iter.sv ====
//--------------------------------------------------------------------------
// Iterative unsigned square root, four root bits per cycle
// root_op is used directly in STEP0 and captured for the later steps
// root is valid only while root_done is high
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ialu_consts.svh"

module ialu_sqrt_iter
    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    root_start,
    input  ialu_word_t              root_op,
    output logic [`IALU_ROOT_W-1:0] root,
    output logic                    root_done
);

    localparam int XLEN      = `IALU_XLEN;
    localparam int ROOT_W    = `IALU_ROOT_W;
    localparam int ROOT_STEP = `IALU_ROOT_STEP;

    ialu_root_state_e  state;
    ialu_root_state_e  state_next;
    ialu_word_t        op_q;            // Captured operand
    ialu_word_t        op_src;
    logic [ROOT_W-1:0] root_q;          // Bits decided so far
    logic [ROOT_W-1:0] root_base;
    logic [ROOT_W-1:0] root_d;
    logic [ROOT_W-1:0] trial;
    logic [ROOT_W-1:0] prefix;
    ialu_word_t        prefix_sq;
    ialu_word_t        op_top;
    int                bit_idx;

    //----------------------------------------------------------------------
    // Step FSM
    //----------------------------------------------------------------------
    always_comb begin
        case (state)
            STEP0:   state_next = root_start ? STEP1 : STEP0;
            STEP1:   state_next = STEP2;
            STEP2:   state_next = STEP3;
            default: state_next = STEP0;
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            state <= STEP0;
        end else begin
            state <= state_next;
        end
    end

    //----------------------------------------------------------------------
    // Bit decision
    //----------------------------------------------------------------------
    assign op_src    = (state == STEP0) ? root_op : op_q;
    assign root_base = (state == STEP0) ? '0 : root_q;

    // Trial bit stays when prefix^2 fits in the matching operand top bits
    always_comb begin
        root_d = root_base;
        for (int k = 0; k < ROOT_STEP; k++) begin
            bit_idx   = ROOT_W - 1 - int'(state) * ROOT_STEP - k;
            trial     = root_d | (ROOT_W'(1) << bit_idx);
            prefix    = trial >> bit_idx;
            prefix_sq = XLEN'(prefix) * XLEN'(prefix);
            op_top    = op_src >> (2 * bit_idx);
            if (prefix_sq <= op_top) begin
                root_d = trial;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (root_start) begin
            op_q <= root_op;
        end
        root_q <= root_d;
    end

    assign root      = root_d;              // Final bits settle in STEP3
    assign root_done = (state == STEP3);

endmodule : ialu_sqrt_iter

`default_nettype wire

// ==== hw/ialu_exec.sv ====
//--------------------------------------------------------------------------
// Execute stage with the result register
// Non-root results come one edge after issue, roots three edges later
// Flags are meaningful for subtraction only
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ialu_consts.svh"

module ialu_exec
    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        issue_vd,
    input  ialu_issue_s issue,
    output logic        exec_stall,
    output logic        res_vd,
    output ialu_word_t  res,
    output logic        cmp
);

    localparam int XLEN   = `IALU_XLEN;
    localparam int ROOT_W = `IALU_ROOT_W;

    logic [XLEN:0]     sum_res;         // Carry in the top bit
    ialu_flags_s       flags;
    logic              cmp_bit;
    ialu_word_t        logic_res;
    ialu_shamt_t       shamt;
    ialu_word_t        shift_res;
    ialu_word_t        res_sel;
    logic              root_start;
    logic              root_busy;       // Engine past its first step
    logic              root_done;
    logic [ROOT_W-1:0] root;
    logic              op_done;

    //----------------------------------------------------------------------
    // Adder and flags
    //----------------------------------------------------------------------
    always_comb begin
        sum_res = issue.sub ? ({1'b0, issue.op1} - {1'b0, issue.op2})
                            : ({1'b0, issue.op1} + {1'b0, issue.op2});
        flags.carry    = sum_res[XLEN];
        flags.zero     = ~|sum_res[XLEN-1:0];
        flags.sign     = sum_res[XLEN-1];
        flags.overflow = (~issue.op1[XLEN-1] &  issue.op2[XLEN-1] &  sum_res[XLEN-1]) |
                         ( issue.op1[XLEN-1] & ~issue.op2[XLEN-1] & ~sum_res[XLEN-1]);
    end

    always_comb begin
        case (issue.cmd)
            SLT:     cmp_bit = flags.sign ^ flags.overflow;
            SLTU:    cmp_bit = flags.carry;
            EQ:      cmp_bit = flags.zero;
            NE:      cmp_bit = ~flags.zero;
            GE:      cmp_bit = ~(flags.sign ^ flags.overflow);
            GEU:     cmp_bit = ~flags.carry;
            default: cmp_bit = 1'b0;        // Not a compare
        endcase
    end

    //----------------------------------------------------------------------
    // Logic and shifts
    //----------------------------------------------------------------------
    always_comb begin
        case (issue.cmd)
            AND:     logic_res = issue.op1 & issue.op2;
            OR:      logic_res = issue.op1 | issue.op2;
            default: logic_res = issue.op1 ^ issue.op2;
        endcase
    end

    assign shamt = issue.op2[`IALU_SHAMT_W-1:0];

    always_comb begin
        if (~issue.shift_right) begin
            shift_res = issue.op1 << shamt;
        end else if (issue.shift_arith) begin
            shift_res = ialu_word_t'($signed(issue.op1) >>> shamt);
        end else begin
            shift_res = issue.op1 >> shamt;
        end
    end

    //----------------------------------------------------------------------
    // Root engine control
    //----------------------------------------------------------------------
    assign root_start = issue_vd & (issue.op_class == ROOT) & ~root_busy;
    assign exec_stall = root_start | (root_busy & ~root_done);
    assign op_done    = (issue_vd & (issue.op_class != ROOT)) | root_done;

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            root_busy <= 1'b0;
        end else if (root_done) begin
            root_busy <= 1'b0;
        end else if (root_start) begin
            root_busy <= 1'b1;
        end
    end

    ialu_sqrt_iter sqrt0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .root_start (root_start),
        .root_op    (issue.op1),
        .root       (root),
        .root_done  (root_done)
    );

    //----------------------------------------------------------------------
    // Result register
    //----------------------------------------------------------------------
    always_comb begin
        case (issue.op_class)
            LOGIC:   res_sel = logic_res;
            CMP:     res_sel = ialu_word_t'(cmp_bit);
            SHIFT:   res_sel = shift_res;
            ROOT:    res_sel = ialu_word_t'(root);
            default: res_sel = sum_res[XLEN-1:0];
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (~rst_n) begin
            res_vd <= 1'b0;
            cmp    <= 1'b0;
        end else begin
            res_vd <= op_done;              // One pulse per result
            if (op_done) begin
                cmp <= cmp_bit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_done) begin
            res <= res_sel;
        end
    end

endmodule : ialu_exec

`default_nettype wire

// ==== hw/ialu_top.sv ====
//--------------------------------------------------------------------------
// Pipelined integer ALU top level
// Accepts on a rising edge with ialu_vd and ialu_rdy both high
// The consumer must take res in the cycle res_vd is high
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ialu_top
    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ialu_vd,
    input  ialu_cmd_e  ialu_cmd,
    input  ialu_word_t ialu_op1,
    input  ialu_word_t ialu_op2,
    output logic       ialu_rdy,
    output logic       res_vd,
    output ialu_word_t res,
    output logic       cmp
);

    logic        issue_vd;      // Issue register holds an operation
    ialu_issue_s issue;
    logic        exec_stall;    // Root in progress

    ialu_issue issue0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .ialu_vd    (ialu_vd),
        .ialu_cmd   (ialu_cmd),
        .ialu_op1   (ialu_op1),
        .ialu_op2   (ialu_op2),
        .exec_stall (exec_stall),
        .ialu_rdy   (ialu_rdy),
        .issue_vd   (issue_vd),
        .issue      (issue)
    );

    ialu_exec exec0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_vd   (issue_vd),
        .issue      (issue),
        .exec_stall (exec_stall),
        .res_vd     (res_vd),
        .res        (res),
        .cmp        (cmp)
    );

endmodule : ialu_top

`default_nettype wire

// ==== sim/tb_clock.sv ====
//--------------------------------------------------------------------------
// Free running testbench clock, starts low
// PERIOD_NS should be even so both phases are whole nanoseconds
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;    // Half period per phase
    end

endmodule : tb_clock

`default_nettype wire

// ==== sim/ialu_checker.sv ====
//--------------------------------------------------------------------------
// Protocol assertions for the ALU top level, attached by bind
// All checks are disabled while rst_n is low
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ialu_checker
    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ialu_vd,
    input  ialu_cmd_e  ialu_cmd,
    input  logic       ialu_rdy,
    input  logic       res_vd,
    input  ialu_word_t res
);

    // Control outputs always driven
    a_ctrl_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({res_vd, ialu_rdy}))
        else $error("res_vd or ialu_rdy is unknown");

    a_res_known: assert property (@(posedge clk) disable iff (!rst_n)
        res_vd |-> !$isunknown(res))
        else $error("res is unknown while res_vd is high");

    // Root stalls three cycles, result one edge after ialu_rdy returns
    a_sqrt_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (ialu_vd && ialu_rdy && ialu_cmd == SQRT) |=>
            !ialu_rdy ##1 !ialu_rdy ##1 !ialu_rdy ##1 ialu_rdy ##1 res_vd)
        else $error("SQRT stall window or result timing is wrong");

endmodule : ialu_checker

bind ialu_top ialu_checker chk0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .ialu_vd  (ialu_vd),
    .ialu_cmd (ialu_cmd),
    .ialu_rdy (ialu_rdy),
    .res_vd   (res_vd),
    .res      (res)
);

`default_nettype wire

// ==== sim/ialu_tb.sv ====
//--------------------------------------------------------------------------
// Directed tests of the pipelined ALU
// Results are compared in issue order against a reference model
// Latency is counted in rising edges from the acceptance edge
//--------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ialu_tb
    import ialu_cmd_pkg::*;
    import ialu_data_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 8;
    localparam int N_OPS      = 85 + 150 + 36 + 24 + 68;    // Sum over all tests
    localparam int WDOG_CYC   = N_OPS * 8 + RST_CYCLES + 100;

    typedef struct packed {
        ialu_word_t  res;
        logic        cmp;
        logic        root;      // Four-edge latency
        logic [63:0] t_acc;     // Time of the acceptance edge
    } expect_s;

    logic       clk;
    logic       rst_n;
    logic       ialu_vd;
    ialu_cmd_e  ialu_cmd;
    ialu_word_t ialu_op1;
    ialu_word_t ialu_op2;
    logic       ialu_rdy;
    logic       res_vd;
    ialu_word_t res;
    logic       cmp;

    expect_s exp_q[$];
    int      n_checks    = 0;
    int      val_errs    = 0;
    int      time_errs   = 0;
    int      other_errs  = 0;
    int      res_run     = 0;   // Consecutive res_vd pulses
    int      max_run     = 0;
    logic    report_done = 1'b0;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) clk0 (.clk(clk));

    ialu_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ialu_vd  (ialu_vd),
        .ialu_cmd (ialu_cmd),
        .ialu_op1 (ialu_op1),
        .ialu_op2 (ialu_op2),
        .ialu_rdy (ialu_rdy),
        .res_vd   (res_vd),
        .res      (res),
        .cmp      (cmp)
    );

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------
    function automatic expect_s expected_result(input ialu_cmd_e c, input ialu_word_t a,
                                                input ialu_word_t b);
        expect_s e;
        logic    t;
        longint  r;
        e = '0;
        t = 1'b0;
        case (c)
            ADD:  e.res = a + b;
            SUB:  e.res = a - b;
            AND:  e.res = a & b;
            OR:   e.res = a | b;
            XOR:  e.res = a ^ b;
            SLT:  t = $signed(a) < $signed(b);
            SLTU: t = a < b;
            EQ:   t = a == b;
            NE:   t = a != b;
            GE:   t = $signed(a) >= $signed(b);
            GEU:  t = a >= b;
            SLL:  e.res = a << b[4:0];
            SRL:  e.res = a >> b[4:0];
            SRA:  e.res = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            default: begin
                r = longint'($sqrt(real'(a)));      // Trim rounding both ways
                while (r * r > longint'(a)) begin
                    r = r - 1;
                end
                while ((r + 1) * (r + 1) <= longint'(a)) begin
                    r = r + 1;
                end
                e.res  = ialu_word_t'(r);
                e.root = 1'b1;
            end
        endcase
        if (t) begin
            e.res = 32'd1;                          // Compares only
            e.cmp = 1'b1;
        end
        return e;
    endfunction

    //----------------------------------------------------------------------
    // Driver and result monitor
    //----------------------------------------------------------------------
    // Called just after a falling edge, returns one falling edge after acceptance
    task automatic issue_op(input ialu_cmd_e c, input ialu_word_t a, input ialu_word_t b);
        expect_s e;
        e        = expected_result(c, a, b);
        ialu_vd  = 1'b1;
        ialu_cmd = c;
        ialu_op1 = a;
        ialu_op2 = b;
        while (!ialu_rdy) begin
            @(negedge clk);                         // Hold inputs while stalled
        end
        @(posedge clk);
        e.t_acc = $time;
        exp_q.push_back(e);
        @(negedge clk);
        ialu_vd = 1'b0;
    endtask

    task automatic check_result();
        expect_s e;
        int      lat;
        int      exp_lat;
        if (exp_q.size() == 0) begin
            other_errs++;
            $display("res_vd pulsed at %0t with no operation outstanding", $time);
            return;
        end
        e       = exp_q.pop_front();
        lat     = int'(($time - e.t_acc - CLK_PERIOD / 2) / CLK_PERIOD);
        exp_lat = e.root ? 4 : 1;
        n_checks++;
        if (res !== e.res) begin
            val_errs++;
            $display("Error at %0t: res expected %h, got %h", $time, e.res, res);
        end
        if (cmp !== e.cmp) begin
            val_errs++;
            $display("Error at %0t: cmp expected %b, got %b", $time, e.cmp, cmp);
        end
        if (lat != exp_lat) begin
            time_errs++;
            $display("Error at %0t: res_vd latency expected %0d edges, got %0d",
                     $time, exp_lat, lat);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && res_vd) begin
            res_run = res_run + 1;
            if (res_run > max_run) begin
                max_run = res_run;
            end
            check_result();
        end else begin
            res_run = 0;
        end
    end

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d operations never produced res_vd", exp_q.size());
        end
    endtask

    //----------------------------------------------------------------------
    // Tests
    //----------------------------------------------------------------------
    task automatic test_logic_arith();
        ialu_word_t vals[3];
        ialu_cmd_e  cmds[5];
        vals = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000};
        cmds = '{AND, OR, XOR, ADD, SUB};
        foreach (cmds[c]) begin
            foreach (vals[i]) begin
                foreach (vals[j]) begin
                    issue_op(cmds[c], vals[i], vals[j]);
                end
            end
            repeat (8) issue_op(cmds[c], $urandom, $urandom);
        end
    endtask

    task automatic test_compare();
        ialu_word_t vals[5];
        ialu_cmd_e  cmds[6];
        vals = '{32'h0, 32'h1, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
        cmds = '{SLT, SLTU, EQ, NE, GE, GEU};
        foreach (cmds[c]) begin
            foreach (vals[i]) begin
                foreach (vals[j]) begin
                    issue_op(cmds[c], vals[i], vals[j]);
                end
            end
        end
    endtask

    task automatic test_shift();
        ialu_word_t amts[4];
        ialu_cmd_e  cmds[3];
        amts = '{32'h0, 32'd31, 32'h21, 32'hffff_ffe4};    // Upper bits ignored
        cmds = '{SLL, SRL, SRA};
        foreach (cmds[c]) begin
            foreach (amts[i]) begin
                issue_op(cmds[c], 32'h8765_4321, amts[i]);
            end
            repeat (8) issue_op(cmds[c], $urandom, $urandom);
        end
    endtask

    // Checks ialu_rdy for the three stall cycles and its return
    task automatic check_stall_window();
        logic exp_rdy;
        for (int k = 0; k < 4; k++) begin
            exp_rdy = (k == 3);
            if (ialu_rdy !== exp_rdy) begin
                time_errs++;
                $display("Error at %0t: ialu_rdy expected %b, got %b",
                         $time, exp_rdy, ialu_rdy);
            end
            if (k < 3) begin
                @(negedge clk);
            end
        end
    endtask

    task automatic test_sqrt();
        ialu_word_t vals[12];
        vals = '{32'd0, 32'd1, 32'd4, 32'd15, 32'd16, 32'd65024, 32'd65025,
                 32'h3fff_ffff, 32'h4000_0000, 32'hfffe_0000, 32'hfffe_0001,
                 32'hffff_ffff};
        foreach (vals[i]) begin
            issue_op(SQRT, vals[i], $urandom);
            check_stall_window();
        end
        repeat (12) begin
            issue_op(SQRT, $urandom, $urandom);
            check_stall_window();
        end
    endtask

    task automatic test_stream();
        repeat (60) begin
            issue_op(ialu_cmd_e'(4'($urandom_range(14, 0))), $urandom, $urandom);
        end
        wait_drain();
        repeat (2) @(posedge clk);
        max_run = 0;
        @(negedge clk);
        repeat (8) begin
            issue_op(ialu_cmd_e'(4'($urandom_range(13, 0))), $urandom, $urandom);
        end
        wait_drain();
        if (max_run < 8) begin
            time_errs++;
            $display("Back-to-back operations gave only %0d consecutive results", max_run);
        end
    endtask

    //----------------------------------------------------------------------
    // Main sequence, watchdog and report
    //----------------------------------------------------------------------
    initial begin
        void'($urandom(32'ha433_26cb));
        rst_n    = 1'b0;
        ialu_vd  = 1'b0;
        ialu_cmd = ADD;
        ialu_op1 = '0;
        ialu_op2 = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_logic_arith();
        test_compare();
        test_shift();
        test_sqrt();
        test_stream();
        wait_drain();
        report_done = 1'b1;
        $display("Checks %0d, value errors %0d, timing errors %0d, other errors %0d",
                 n_checks, val_errs, time_errs, other_errs);
        if (val_errs + time_errs + other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(WDOG_CYC * CLK_PERIOD);
        report_done = 1'b1;
        $display("Watchdog expired after %0d cycles, the run did not complete", WDOG_CYC);
        $display("Test FAILED");
        $finish;
    end

    // Run stopped early, for instance by a failed assertion
    final begin
        if (!report_done) begin
            $display("Test FAILED");
        end
    end

endmodule : ialu_tb

`default_nettype wire

// ==== ialu_top.f ====
+incdir+hw
hw/ialu_cmd_pkg.sv
hw/ialu_data_pkg.sv
hw/ialu_issue.sv
hw/ialu_sqrt_iter.sv
hw/ialu_exec.sv
hw/ialu_top.sv
sim/tb_clock.sv
sim/ialu_checker.sv
sim/ialu_tb.sv

// ==== Makefile ====
# Verilator build and run of the integer ALU testbench

TOP := ialu_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f ialu_top.f -Mdir obj_dir

# Fails unless the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
